// File: rtl/rv_alu.sv
`timescale 1ns/1ns

module rv_alu (
    input  rv_pkg::alu_ctrl_t ctrl_i,
    input  rv_pkg::word_t     src1_i,
    input  rv_pkg::word_t     src2_i,
    output rv_pkg::word_t     rslt_o
);
    import rv_pkg::*;

    logic [33:0]       add_a;
    logic [33:0]       add_b;
    logic [33:0]       add_sum;
    logic signed [32:0] shr_src;
    logic [4:0]        shamt;
    word_t             add_rslt;
    word_t             less_rslt;
    word_t             sll_rslt;
    word_t             srl_rslt;
    word_t             bit_rslt;
    word_t             pass_rslt;

    // low guard bit supplies the +1 of a subtract
    assign add_a   = {ctrl_i.is_signed & src1_i[31], src1_i, 1'b1};
    assign add_b   = {ctrl_i.is_signed & src2_i[31], src2_i, 1'b0} ^ {34{ctrl_i.is_neg}};
    assign add_sum = add_a + add_b;

    assign add_rslt  = ctrl_i.is_add ? add_sum[32:1] : '0;
    assign less_rslt = {31'b0, ctrl_i.is_less & add_sum[33]}; // sign of the difference

    assign shamt    = src2_i[4:0];
    assign shr_src  = {ctrl_i.is_signed & src1_i[31], src1_i};
    assign sll_rslt = ctrl_i.is_sll ? src1_i << shamt : '0;
    assign srl_rslt = ctrl_i.is_srl ? word_t'(shr_src >>> shamt) : '0;

    assign bit_rslt = (ctrl_i.is_xor_or ? (src1_i ^ src2_i) : '0)
                    | (ctrl_i.is_or_and ? (src1_i & src2_i) : '0);

    assign pass_rslt = ctrl_i.is_src2 ? src2_i : '0;

    // only one group is active per instruction
    assign rslt_o = add_rslt | less_rslt | sll_rslt | srl_rslt | bit_rslt | pass_rslt;

endmodule

// File: rtl/rv_dec_if.sv
`timescale 1ns/1ns

interface rv_dec_if;
    import rv_pkg::*;

    alu_ctrl_t alu_ctrl;
    lsu_ctrl_t lsu_ctrl;
    logic      use_imm;
    logic      use_pc;   // imm already holds pc + offset
    word_t     imm;
    logic      rf_we;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;

    modport dec (output alu_ctrl, lsu_ctrl, use_imm, use_pc, imm, rf_we, rd, rs1, rs2);
    modport pipe (input alu_ctrl, lsu_ctrl, use_imm, use_pc, imm, rf_we, rd, rs1, rs2);

endinterface

// File: rtl/rv_decoder.sv
`timescale 1ns/1ns

module rv_decoder (
    input  rv_pkg::word_t insn_i,
    input  rv_pkg::word_t pc_i,
    rv_dec_if.dec         dec_o
);
    import rv_pkg::*;

    logic [4:0] op;
    logic [2:0] f3;
    logic [6:0] f7;
    logic       known;
    logic       is_op;
    logic       is_imm_op;
    insn_fmt_e  fmt;
    word_t      imm_raw;

    assign op = insn_i[6:2];
    assign f3 = insn_i[14:12];
    assign f7 = insn_i[31:25];

    // ------------------------------
    // pre-decode
    // ------------------------------
    always_comb begin
        known = 1'b1;
        case (op)
            OPC_LOAD, OPC_OP_IMM: fmt = FMT_I;
            OPC_STORE:            fmt = FMT_S;
            OPC_LUI, OPC_AUIPC:   fmt = FMT_U;
            OPC_OP:               fmt = FMT_NONE;
            default: begin
                fmt   = FMT_NONE;
                known = 1'b0;
            end
        endcase
    end

    assign dec_o.rd    = (fmt == FMT_S || !known) ? '0 : insn_i[11:7];
    assign dec_o.rs1   = (fmt == FMT_U) ? '0 : insn_i[19:15];
    assign dec_o.rs2   = (fmt == FMT_I || fmt == FMT_U) ? '0 : insn_i[24:20];
    assign dec_o.rf_we = (dec_o.rd != '0);

    // ------------------------------
    // control decode
    // ------------------------------
    assign is_op     = (op == OPC_OP) && (f7 == 7'b0000000 || f7 == 7'b0100000);
    assign is_imm_op = (op == OPC_OP_IMM);

    always_comb begin
        dec_o.alu_ctrl = '0;
        if (is_op || is_imm_op) begin
            case (f3)
                3'd0: begin
                    dec_o.alu_ctrl.is_add = 1'b1;
                    dec_o.alu_ctrl.is_neg = is_op && f7[5];  // sub
                end
                3'd1: dec_o.alu_ctrl.is_sll = 1'b1;
                3'd2: begin                                 // slt
                    dec_o.alu_ctrl.is_signed = 1'b1;
                    dec_o.alu_ctrl.is_neg    = 1'b1;
                    dec_o.alu_ctrl.is_less   = 1'b1;
                end
                3'd3: begin                                 // sltu
                    dec_o.alu_ctrl.is_neg  = 1'b1;
                    dec_o.alu_ctrl.is_less = 1'b1;
                end
                3'd4: dec_o.alu_ctrl.is_xor_or = 1'b1;
                3'd5: begin
                    dec_o.alu_ctrl.is_srl    = 1'b1;
                    dec_o.alu_ctrl.is_signed = f7[5];       // sra
                end
                3'd6: begin                                 // or = xor | and
                    dec_o.alu_ctrl.is_xor_or = 1'b1;
                    dec_o.alu_ctrl.is_or_and = 1'b1;
                end
                default: dec_o.alu_ctrl.is_or_and = 1'b1;
            endcase
        end
        dec_o.alu_ctrl.is_src2 = (op == OPC_LUI) || (op == OPC_AUIPC);
    end

    always_comb begin
        dec_o.lsu_ctrl           = '0;
        dec_o.lsu_ctrl.is_load   = (op == OPC_LOAD);
        dec_o.lsu_ctrl.is_store  = (op == OPC_STORE);
        dec_o.lsu_ctrl.is_signed = (op == OPC_LOAD) && !f3[2];
        if (op == OPC_LOAD || op == OPC_STORE) begin
            dec_o.lsu_ctrl.is_byte = (f3[1:0] == 2'd0);
            dec_o.lsu_ctrl.is_half = (f3[1:0] == 2'd1);
            dec_o.lsu_ctrl.is_word = (f3[1:0] == 2'd2);
        end
    end

    // ------------------------------
    // immediate
    // ------------------------------
    always_comb begin
        case (fmt)
            FMT_I:   imm_raw = {{20{insn_i[31]}}, insn_i[31:20]};
            FMT_S:   imm_raw = {{20{insn_i[31]}}, insn_i[31:25], insn_i[11:7]};
            FMT_U:   imm_raw = {insn_i[31:12], 12'b0};
            default: imm_raw = '0;
        endcase
    end

    assign dec_o.use_pc  = (op == OPC_AUIPC);
    assign dec_o.use_imm = (fmt == FMT_I) || (fmt == FMT_S) || (op == OPC_LUI);
    assign dec_o.imm     = dec_o.use_pc ? pc_i + imm_raw : imm_raw; // auipc folded here

endmodule

// File: rtl/rv_lsu.sv
`timescale 1ns/1ns

module rv_lsu (
    input  logic              valid_i,
    input  logic              stall_i,
    // execute side
    input  rv_pkg::lsu_ctrl_t st_ctrl_i,
    input  rv_pkg::word_t     base_i,
    input  rv_pkg::word_t     imm_i,
    input  rv_pkg::word_t     st_data_i,
    output rv_pkg::word_t     dbus_addr_o,
    output rv_pkg::word_t     dbus_wdata_o,
    output logic              dbus_wvalid_o,
    output logic [3:0]        dbus_wstrb_o,
    output logic [1:0]        offset_o,
    // memory access side
    input  rv_pkg::lsu_ctrl_t ld_ctrl_i,
    input  logic [1:0]        ld_offset_i,
    input  rv_pkg::word_t     dbus_rdata_i,
    output rv_pkg::word_t     ld_rslt_o
);
    import rv_pkg::*;

    word_t lane;

    // ------------------------------
    // store
    // ------------------------------
    assign dbus_addr_o   = base_i + imm_i;
    assign offset_o      = dbus_addr_o[1:0];
    assign dbus_wvalid_o = valid_i && !stall_i && st_ctrl_i.is_store;

    assign dbus_wdata_o = st_ctrl_i.is_byte ? {4{st_data_i[7:0]}}  :
                          st_ctrl_i.is_half ? {2{st_data_i[15:0]}} : st_data_i;

    always_comb begin
        if (st_ctrl_i.is_byte) begin
            dbus_wstrb_o = 4'b0001 << offset_o;
        end else if (st_ctrl_i.is_half) begin
            dbus_wstrb_o = offset_o[1] ? 4'b1100 : 4'b0011;
        end else if (st_ctrl_i.is_word) begin
            dbus_wstrb_o = 4'b1111;
        end else begin
            dbus_wstrb_o = 4'b0000;
        end
    end

    // ------------------------------
    // load
    // ------------------------------
    assign lane = dbus_rdata_i >> {ld_offset_i, 3'b000}; // addressed byte to lane 0

    always_comb begin
        if (!ld_ctrl_i.is_load) begin
            ld_rslt_o = '0;
        end else if (ld_ctrl_i.is_byte) begin
            ld_rslt_o = {{24{ld_ctrl_i.is_signed & lane[7]}}, lane[7:0]};
        end else if (ld_ctrl_i.is_half) begin
            ld_rslt_o = {{16{ld_ctrl_i.is_signed & lane[15]}}, lane[15:0]};
        end else begin
            ld_rslt_o = dbus_rdata_i;
        end
    end

endmodule

// File: rtl/rv_pipe_core.sv
`timescale 1ns/1ns

module rv_pipe_core #(
    parameter rv_pkg::word_t RESET_VECTOR = '0
) (
    input  logic          clk_i,
    input  logic          rst,
    input  logic          stall_i,
    output rv_pkg::word_t ibus_addr_o,
    input  rv_pkg::word_t ibus_rdata_i,
    output rv_pkg::word_t dbus_addr_o,
    output rv_pkg::word_t dbus_wdata_o,
    output logic          dbus_wvalid_o,
    output logic [3:0]    dbus_wstrb_o,
    input  rv_pkg::word_t dbus_rdata_i
);
    import rv_pkg::*;

    localparam if_id_t IF_ID_RST = '{pc: RESET_VECTOR, insn: NOP_INSN};

    word_t  r_pc;       // address of the word on ibus_rdata_i
    logic   fetch_v;    // first read after reset is still in flight
    logic   load_use;

    if_id_t if_id_d, if_id_q;
    id_ex_t id_ex_d, id_ex_q;
    ex_ma_t ex_ma_d, ex_ma_q;
    ma_wb_t ma_wb_d, ma_wb_q;
    logic   if_id_v, id_ex_v, ex_ma_v, ma_wb_v;

    // ------------------------------
    // fetch
    // ------------------------------
    assign ibus_addr_o = (fetch_v && !load_use) ? r_pc + 32'd4 : r_pc;

    always_ff @(posedge clk_i) begin
        if (rst) begin
            r_pc    <= RESET_VECTOR;
            fetch_v <= 1'b0;
        end else if (!stall_i) begin
            r_pc    <= ibus_addr_o;
            fetch_v <= 1'b1;
        end
    end

    always_comb begin
        if_id_d.pc   = r_pc;
        if_id_d.insn = ibus_rdata_i;
    end

    rv_stage_reg #(.payload_t(if_id_t), .RST_DATA(IF_ID_RST)) if_id (
        .clk_i   (clk_i),
        .rst     (rst),
        .stall_i (stall_i),
        .hold_i  (load_use),      // consumer waits in decode
        .bubble_i(1'b0),
        .valid_i (fetch_v),
        .data_i  (if_id_d),
        .valid_o (if_id_v),
        .data_o  (if_id_q)
    );

    // ------------------------------
    // decode
    // ------------------------------
    rv_dec_if dec_if ();

    rv_decoder u_decoder (
        .insn_i(if_id_q.insn),
        .pc_i  (if_id_q.pc),
        .dec_o (dec_if.dec)
    );

    word_t rf_rs1, rf_rs2;
    word_t ma_rslt;
    word_t ld_rslt;
    word_t rs1_val, rs2_val;
    logic  ma_hit1, ma_hit2, ex_hit1, ex_hit2;
    logic  imm_src2;

    rv_regfile u_regfile (
        .clk_i     (clk_i),
        .stall_i   (stall_i),
        .rs1_i     (dec_if.rs1),
        .rs2_i     (dec_if.rs2),
        .rs1_data_o(rf_rs1),
        .rs2_data_o(rf_rs2),
        .we_i      (ma_wb_v && ma_wb_q.rf_we),
        .rd_i      (ma_wb_q.rd),
        .wdata_i   (ma_wb_q.rslt)
    );

    // rf_we implies rd != 0, so x0 never matches
    assign ex_hit1 = id_ex_v && id_ex_q.rf_we && (id_ex_q.rd == dec_if.rs1);
    assign ex_hit2 = id_ex_v && id_ex_q.rf_we && (id_ex_q.rd == dec_if.rs2);
    assign ma_hit1 = ex_ma_v && ex_ma_q.rf_we && (ex_ma_q.rd == dec_if.rs1);
    assign ma_hit2 = ex_ma_v && ex_ma_q.rf_we && (ex_ma_q.rd == dec_if.rs2);

    assign load_use = if_id_v && id_ex_q.lsu.is_load && (ex_hit1 || ex_hit2);

    assign imm_src2 = dec_if.use_imm || dec_if.use_pc;
    assign rs1_val  = ma_hit1 ? ma_rslt : rf_rs1;  // ma result includes load data
    assign rs2_val  = ma_hit2 ? ma_rslt : rf_rs2;

    always_comb begin
        id_ex_d.alu      = dec_if.alu_ctrl;
        id_ex_d.lsu      = dec_if.lsu_ctrl;
        id_ex_d.src1     = rs1_val;
        id_ex_d.src2     = imm_src2 ? dec_if.imm : rs2_val;
        id_ex_d.st_data  = rs2_val;
        id_ex_d.fwd_src1 = ex_hit1;
        id_ex_d.fwd_src2 = ex_hit2 && !imm_src2;
        id_ex_d.fwd_st   = ex_hit2;
        id_ex_d.rf_we    = dec_if.rf_we;
        id_ex_d.rd       = dec_if.rd;
    end

    rv_stage_reg #(.payload_t(id_ex_t)) id_ex (
        .clk_i   (clk_i),
        .rst     (rst),
        .stall_i (stall_i),
        .hold_i  (1'b0),
        .bubble_i(load_use),
        .valid_i (if_id_v),
        .data_i  (id_ex_d),
        .valid_o (id_ex_v),
        .data_o  (id_ex_q)
    );

    // ------------------------------
    // execute
    // ------------------------------
    word_t ex_src1, ex_src2, ex_st_data, alu_rslt;
    logic [1:0] ex_offset;

    assign ex_src1    = id_ex_q.fwd_src1 ? ex_ma_q.rslt : id_ex_q.src1;
    assign ex_src2    = id_ex_q.fwd_src2 ? ex_ma_q.rslt : id_ex_q.src2;
    assign ex_st_data = id_ex_q.fwd_st   ? ex_ma_q.rslt : id_ex_q.st_data;

    rv_alu u_alu (
        .ctrl_i(id_ex_q.alu),
        .src1_i(ex_src1),
        .src2_i(ex_src2),
        .rslt_o(alu_rslt)
    );

    rv_lsu u_lsu (
        .valid_i      (id_ex_v),
        .stall_i      (stall_i),
        .st_ctrl_i    (id_ex_q.lsu),
        .base_i       (ex_src1),
        .imm_i        (ex_src2),       // src2 holds the offset for memory ops
        .st_data_i    (ex_st_data),
        .dbus_addr_o  (dbus_addr_o),
        .dbus_wdata_o (dbus_wdata_o),
        .dbus_wvalid_o(dbus_wvalid_o),
        .dbus_wstrb_o (dbus_wstrb_o),
        .offset_o     (ex_offset),
        .ld_ctrl_i    (ex_ma_q.lsu),
        .ld_offset_i  (ex_ma_q.offset),
        .dbus_rdata_i (dbus_rdata_i),
        .ld_rslt_o    (ld_rslt)
    );

    always_comb begin
        ex_ma_d.rslt   = alu_rslt;
        ex_ma_d.lsu    = id_ex_q.lsu;
        ex_ma_d.offset = ex_offset;
        ex_ma_d.rf_we  = id_ex_q.rf_we;
        ex_ma_d.rd     = id_ex_q.rd;
    end

    rv_stage_reg #(.payload_t(ex_ma_t)) ex_ma (
        .clk_i   (clk_i),
        .rst     (rst),
        .stall_i (stall_i),
        .hold_i  (1'b0),
        .bubble_i(1'b0),
        .valid_i (id_ex_v),
        .data_i  (ex_ma_d),
        .valid_o (ex_ma_v),
        .data_o  (ex_ma_q)
    );

    // ------------------------------
    // memory access / write back
    // ------------------------------
    assign ma_rslt = ex_ma_q.rslt | ld_rslt;  // alu result is zero for loads

    always_comb begin
        ma_wb_d.rslt  = ma_rslt;
        ma_wb_d.rf_we = ex_ma_q.rf_we;
        ma_wb_d.rd    = ex_ma_q.rd;
    end

    rv_stage_reg #(.payload_t(ma_wb_t)) ma_wb (
        .clk_i   (clk_i),
        .rst     (rst),
        .stall_i (stall_i),
        .hold_i  (1'b0),
        .bubble_i(1'b0),
        .valid_i (ex_ma_v),
        .data_i  (ma_wb_d),
        .valid_o (ma_wb_v),
        .data_o  (ma_wb_q)
    );

endmodule

// File: rtl/rv_pkg.sv
package rv_pkg;

    // ------------------------------
    // widths and constants
    // ------------------------------
    localparam int XLEN = 32;

    typedef logic [4:0]      reg_addr_t;
    typedef logic [XLEN-1:0] word_t;

    localparam word_t NOP_INSN = 32'h0000_0013; // addi x0,x0,0

    // major opcodes from insn[6:2]
    typedef enum logic [4:0] {
        OPC_LOAD   = 5'b00000,
        OPC_STORE  = 5'b01000,
        OPC_OP_IMM = 5'b00100,
        OPC_OP     = 5'b01100,
        OPC_LUI    = 5'b01101,
        OPC_AUIPC  = 5'b00101
    } opcode_e;

    typedef enum logic [1:0] {
        FMT_I,
        FMT_S,
        FMT_U,
        FMT_NONE // register-register or unknown
    } insn_fmt_e;

    // ------------------------------
    // control groups
    // ------------------------------
    typedef struct packed {
        logic is_signed;
        logic is_neg;      // invert src2 and add one
        logic is_less;
        logic is_add;
        logic is_sll;
        logic is_srl;
        logic is_xor_or;
        logic is_or_and;
        logic is_src2;     // lui, auipc
    } alu_ctrl_t;

    typedef struct packed {
        logic is_load;
        logic is_store;
        logic is_signed;
        logic is_byte;
        logic is_half;
        logic is_word;
    } lsu_ctrl_t;

    // ------------------------------
    // stage payloads
    // ------------------------------
    typedef struct packed {
        word_t pc;
        word_t insn;
    } if_id_t;

    typedef struct packed {
        alu_ctrl_t alu;
        lsu_ctrl_t lsu;
        word_t     src1;
        word_t     src2;
        word_t     st_data;
        logic      fwd_src1;  // take ex/ma alu result in execute
        logic      fwd_src2;
        logic      fwd_st;
        logic      rf_we;
        reg_addr_t rd;
    } id_ex_t;

    typedef struct packed {
        word_t     rslt;
        lsu_ctrl_t lsu;
        logic [1:0] offset;
        logic      rf_we;
        reg_addr_t rd;
    } ex_ma_t;

    typedef struct packed {
        word_t     rslt;
        logic      rf_we;
        reg_addr_t rd;
    } ma_wb_t;

endpackage

// File: rtl/rv_regfile.sv
`timescale 1ns/1ns

module rv_regfile (
    input  logic              clk_i,
    input  logic              stall_i,
    input  rv_pkg::reg_addr_t rs1_i,
    input  rv_pkg::reg_addr_t rs2_i,
    output rv_pkg::word_t     rs1_data_o,
    output rv_pkg::word_t     rs2_data_o,
    input  logic              we_i,
    input  rv_pkg::reg_addr_t rd_i,
    input  rv_pkg::word_t     wdata_i
);
    import rv_pkg::*;

    word_t regs [1:31];

    // x0 reads zero and a same-cycle write is bypassed
    assign rs1_data_o = (rs1_i == '0) ? '0 : (we_i && rs1_i == rd_i) ? wdata_i : regs[rs1_i];
    assign rs2_data_o = (rs2_i == '0) ? '0 : (we_i && rs2_i == rd_i) ? wdata_i : regs[rs2_i];

    always_ff @(posedge clk_i) begin
        if (we_i && !stall_i && rd_i != '0) begin
            regs[rd_i] <= wdata_i;
        end
    end

endmodule

// File: rtl/rv_stage_reg.sv
`timescale 1ns/1ns

module rv_stage_reg #(
    parameter type      payload_t = logic,
    parameter payload_t RST_DATA  = '0
) (
    input  logic     clk_i,
    input  logic     rst,
    input  logic     stall_i,
    input  logic     hold_i,
    input  logic     bubble_i,
    input  logic     valid_i,
    input  payload_t data_i,
    output logic     valid_o,
    output payload_t data_o
);

    always_ff @(posedge clk_i) begin
        if (rst) begin
            valid_o <= 1'b0;
            data_o  <= RST_DATA;
        end else if (!stall_i && !hold_i) begin
            valid_o <= valid_i && !bubble_i; // bubble enters as invalid
            data_o  <= data_i;
        end
    end

endmodule

// File: run.sh
#!/bin/sh
# build the testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f rv_pipe.f --top-module rv_tb
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/Vrv_tb
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

exit 0

// File: rv_pipe.f
+incdir+testbench
rtl/rv_pkg.sv
rtl/rv_dec_if.sv
rtl/rv_decoder.sv
rtl/rv_regfile.sv
rtl/rv_alu.sv
rtl/rv_lsu.sv
rtl/rv_stage_reg.sv
rtl/rv_pipe_core.sv
testbench/rv_pipe_chk.sv
testbench/rv_tb.sv

// File: testbench/rv_pipe_chk.sv
`timescale 1ns/1ns

module rv_pipe_chk (
    input logic          clk_i,
    input logic          rst,
    input logic          stall_i,
    input rv_pkg::word_t ibus_addr_i,
    input logic          wvalid_i,
    input logic [3:0]    wstrb_i
);

    // ------------------------------
    // data bus
    // ------------------------------
    a_quiet_after_reset: assert property (@(posedge clk_i) rst |=> !wvalid_i)
        else $error("write strobe high in the cycle after reset");

    a_no_write_in_stall: assert property (@(posedge clk_i) disable iff (rst)
        stall_i |-> !wvalid_i)
        else $error("write strobe high while the pipeline is frozen");

    // single lane, aligned half or full word
    a_strobe_shape: assert property (@(posedge clk_i) disable iff (rst)
        wvalid_i |-> (wstrb_i inside {4'b0001, 4'b0010, 4'b0100, 4'b1000,
                                      4'b0011, 4'b1100, 4'b1111}))
        else $error("write strobe is not contiguous and aligned");

    // ------------------------------
    // fetch
    // ------------------------------
    a_fetch_held: assert property (@(posedge clk_i) disable iff (rst)
        stall_i |=> $stable(ibus_addr_i))
        else $error("fetch address moved across a frozen cycle");

endmodule

// File: testbench/rv_model.svh
`ifndef RV_MODEL_SVH
`define RV_MODEL_SVH

// ------------------------------
// random source
// ------------------------------
function automatic logic [31:0] rnd(input logic [31:0] n);
    rnd = $unsigned($random(seed)) % n;
endfunction

function automatic logic [4:0] pick_src();
    if (rnd(2) != 0) begin
        pick_src = hist[2'(rnd(3))]; // one of the last destinations
    end else begin
        pick_src = 5'(rnd(32));
    end
endfunction

function automatic logic [31:0] data_addr(input logic [1:0] size);
    data_addr = 32'h100 + (rnd(256) & ~((32'd1 << size) - 32'd1)); // aligned to size
endfunction

// ------------------------------
// reference model
// ------------------------------
function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
    case (f3)
        3'd0:    alu_ref = alt ? a - b : a + b;
        3'd1:    alu_ref = a << b[4:0];
        3'd2:    alu_ref = {31'b0, $signed(a) < $signed(b)};
        3'd3:    alu_ref = {31'b0, a < b};
        3'd4:    alu_ref = a ^ b;
        3'd5:    alu_ref = alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'd6:    alu_ref = a | b;
        default: alu_ref = a & b;
    endcase
endfunction

function automatic logic [31:0] load_ref(input logic [2:0] f3, input logic [31:0] addr);
    logic [31:0] w;
    w = mdata[addr[7:2]] >> (8 * addr[1:0]); // addressed byte down to lane 0
    case (f3)
        3'd0:    load_ref = {{24{w[7]}}, w[7:0]};
        3'd1:    load_ref = {{16{w[15]}}, w[15:0]};
        3'd4:    load_ref = {24'b0, w[7:0]};
        3'd5:    load_ref = {16'b0, w[15:0]};
        default: load_ref = w;
    endcase
endfunction

task automatic store_ref(input logic [31:0] addr, input logic [1:0] size,
                         input logic [31:0] v);
    logic [3:0]  strb;
    logic [31:0] data;
    case (size)
        2'd0:    strb = 4'b0001 << addr[1:0];
        2'd1:    strb = 4'b0011 << addr[1:0];
        default: strb = 4'b1111;
    endcase
    data = (v << (8 * addr[1:0])) & lane_mask(strb);
    for (int i = 0; i < 4; i++) begin
        if (strb[i]) begin
            mdata[addr[7:2]][8*i +: 8] = data[8*i +: 8];
        end
    end
    exp_addr.push_back(addr);
    exp_strb.push_back(strb);
    exp_data.push_back(data);
endtask

// ------------------------------
// program generator with the model running alongside
// ------------------------------
task automatic gen_program();
    logic [31:0] insn, b, v, addr, s, kind;
    logic [4:0]  rd, rs1, rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] imm;
    logic [19:0] uimm;
    int          k;
    for (k = 0; k < IMEM_WORDS; k++) begin
        imem[9'(k)] = NOP_INSN;
    end
    for (k = 0; k < 64; k++) begin
        dinit[6'(k)] = $random(seed);
        mdata[6'(k)] = dinit[6'(k)];
    end
    for (k = 0; k < 3; k++) begin
        hist[2'(k)] = 5'd0;
    end
    mregs[0] = '0;
    for (k = 1; k < 32; k++) begin                   // addi xk, x0, imm
        imm = 12'(rnd(4096));
        imem[9'(k - 1)] = {imm, 5'd0, 3'd0, 5'(k), 7'b0010011};
        mregs[5'(k)] = {{20{imm[11]}}, imm};
    end
    for (k = 31; k < 31 + RAND_LEN; k++) begin
        kind = rnd(100);
        rd   = 5'(rnd(32));
        rs1  = pick_src();
        rs2  = pick_src();
        f3   = 3'(rnd(8));
        v    = '0;
        if (kind < 30) begin                         // op-imm
            imm = 12'(rnd(4096));
            if (f3 == 3'd1 || f3 == 3'd5) begin
                imm[11:5] = (f3 == 3'd5 && rnd(2) != 0) ? 7'h20 : 7'h00;
            end
            insn = {imm, rs1, f3, rd, 7'b0010011};
            b = (f3 == 3'd1 || f3 == 3'd5) ? {27'b0, imm[4:0]} : {{20{imm[11]}}, imm};
            v = alu_ref(f3, f3 == 3'd5 && imm[10], mregs[rs1], b);
        end else if (kind < 55) begin                // register-register
            f7 = ((f3 == 3'd0 || f3 == 3'd5) && rnd(2) != 0) ? 7'h20 : 7'h00;
            insn = {f7, rs2, rs1, f3, rd, 7'b0110011};
            v = alu_ref(f3, f7[5], mregs[rs1], mregs[rs2]);
        end else if (kind < 67) begin                // lui or auipc
            uimm = 20'(rnd(32'h10_0000));
            insn = {uimm, rd, (kind < 61) ? 7'b0110111 : 7'b0010111};
            v = {uimm, 12'b0} + ((kind < 61) ? 32'd0 : 32'(4 * k));
        end else if (kind < 82) begin                // load off x0
            s    = rnd(5);
            f3   = 3'((s < 3) ? s : s + 1);
            addr = data_addr(f3[1:0]);
            insn = {addr[11:0], 5'd0, f3, rd, 7'b0000011};
            v    = load_ref(f3, addr);
        end else begin                               // store off x0
            f3   = 3'(rnd(3));
            addr = data_addr(f3[1:0]);
            insn = {addr[11:5], rs2, 5'd0, f3, addr[4:0], 7'b0100011};
            store_ref(addr, f3[1:0], mregs[rs2]);
            rd   = 5'd0;
        end
        if (rd != 5'd0) begin
            mregs[rd] = v;
        end
        hist[2'(k % 3)] = rd;
        imem[9'(k)] = insn;
    end
    for (k = 1; k < 32; k++) begin                   // final register dump
        addr = 32'h100 + 32'(4 * (k - 1));
        imem[9'(k + 30 + RAND_LEN)] = {addr[11:5], 5'(k), 5'd0, 3'd2, addr[4:0], 7'b0100011};
        store_ref(addr, 2'd2, mregs[5'(k)]);
    end
endtask

`endif

// File: testbench/rv_tb.sv
`timescale 1ns/1ns

module rv_tb;
    import rv_pkg::*;

    localparam int RAND_LEN      = 200;
    localparam int IMEM_WORDS    = 512;
    localparam int STORE_TIMEOUT = 3000; // cycles

    logic       clk        = 1'b0;
    logic       rst        = 1'b1;
    logic       stall      = 1'b0;
    word_t      ibus_addr;
    word_t      ibus_rdata = NOP_INSN;
    word_t      dbus_addr;
    word_t      dbus_wdata;
    logic       dbus_wvalid;
    logic [3:0] dbus_wstrb;
    word_t      dbus_rdata = '0;

    word_t      imem  [0:IMEM_WORDS-1];
    word_t      dinit [0:63];  // data window 0x100..0x1ff
    word_t      dmem  [0:63];
    word_t      mdata [0:63];  // model view of the window
    word_t      mregs [0:31];
    reg_addr_t  hist  [0:2];
    word_t      exp_addr [$];
    word_t      exp_data [$];
    logic [3:0] exp_strb [$];
    int         n_seen = 0;
    int         cycles;
    integer     seed;

    always #20 clk = ~clk;

    rv_pipe_core #(.RESET_VECTOR(32'h0)) UUT (
        .clk_i        (clk),
        .rst          (rst),
        .stall_i      (stall),
        .ibus_addr_o  (ibus_addr),
        .ibus_rdata_i (ibus_rdata),
        .dbus_addr_o  (dbus_addr),
        .dbus_wdata_o (dbus_wdata),
        .dbus_wvalid_o(dbus_wvalid),
        .dbus_wstrb_o (dbus_wstrb),
        .dbus_rdata_i (dbus_rdata)
    );

    bind rv_pipe_core rv_pipe_chk u_chk (
        .clk_i      (clk_i),
        .rst        (rst),
        .stall_i    (stall_i),
        .ibus_addr_i(ibus_addr_o),
        .wvalid_i   (dbus_wvalid_o),
        .wstrb_i    (dbus_wstrb_o)
    );

    function automatic word_t lane_mask(input logic [3:0] strb);
        for (int i = 0; i < 4; i++) begin
            lane_mask[8*i +: 8] = {8{strb[i]}};
        end
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_eq(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            fail_run($sformatf("FAILED at %0t ns: %s got %h expected %h", $time, what, got, exp));
        end
    endtask

    `include "rv_model.svh"

    // ------------------------------
    // memories
    // ------------------------------
    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 64; i++) begin
                dmem[i] <= dinit[i];
            end
        end else if (dbus_wvalid) begin
            for (int i = 0; i < 4; i++) begin
                if (dbus_wstrb[i]) begin
                    dmem[dbus_addr[7:2]][8*i +: 8] <= dbus_wdata[8*i +: 8];
                end
            end
        end
        if (!stall) begin                        // both buses hold while frozen
            ibus_rdata <= imem[ibus_addr[10:2]];
            dbus_rdata <= dmem[dbus_addr[7:2]];
        end
    end

    // every write must be the next one in program order
    always @(posedge clk) begin
        if (!rst && dbus_wvalid) begin
            if (n_seen >= exp_addr.size()) begin
                fail_run("a store appeared after the last expected one");
            end
            check_eq(dbus_addr, exp_addr[n_seen], "store address");
            check_eq({28'b0, dbus_wstrb}, {28'b0, exp_strb[n_seen]}, "store strobe");
            check_eq(dbus_wdata & lane_mask(dbus_wstrb), exp_data[n_seen], "store data");
            n_seen <= n_seen + 1;
        end
    end

    // ------------------------------
    // stimulus
    // ------------------------------
    initial begin
        seed = 71300;
        gen_program();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_eq(ibus_addr, 32'h0, "fetch address after reset");
        check_eq({31'b0, dbus_wvalid}, 32'h0, "write strobe after reset");

        cycles = 0;
        while (n_seen < exp_addr.size()) begin
            @(negedge clk);
            stall = (rnd(100) < 20);             // about one cycle in five
            cycles++;
            if (cycles > STORE_TIMEOUT) begin
                fail_run("timeout while waiting for the expected stores");
            end
        end

        @(negedge clk);
        stall = 1'b0;
        for (cycles = 0; cycles < 24; cycles++) begin // only NOPs left
            @(negedge clk);
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule
